// File: files.f
+incdir+hw
hw/ae_pkg.sv
hw/fixed_mac.sv
hw/dense_layer.sv
hw/autoencoder_top.sv
test/tb_autoencoder.sv

// File: Makefile
TOP = tb_autoencoder

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_$(TOP)

run: build
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: test/tb_autoencoder.sv
`timescale 1ns/1ps
`include "ae_consts.svh"

module tb_autoencoder;

    localparam int clk_period      = 100;                      // ns
    localparam int reset_cycles    = 16;
    localparam int n_vectors       = 24;                       // Accepted starts over all tests
    localparam int watchdog_cycles = n_vectors * 16 + reset_cycles + 200;

    logic clk;
    logic reset;
    logic start;
    ae_pkg::fix_t [`AE_N_IN-1:0]             x;
    ae_pkg::fix_t [`AE_N_HID*`AE_N_IN-1:0]   w_hid;
    ae_pkg::fix_t [`AE_N_HID-1:0]            b_hid;
    ae_pkg::fix_t [`AE_N_CODE*`AE_N_HID-1:0] w_code;
    ae_pkg::fix_t                            b_code;
    ae_pkg::fix_t [`AE_N_IN*`AE_N_CODE-1:0]  w_dec;
    ae_pkg::fix_t [`AE_N_IN-1:0]             b_dec;
    ae_pkg::fix_t                            code;
    logic                                    code_valid;
    ae_pkg::fix_t [`AE_N_IN-1:0]             recon;
    logic                                    recon_valid;

    integer seed;
    int     mismatch_errors;
    int     other_errors;
    logic   start_ok;    // High with a start the DUT must accept
    logic   quiet;       // Window just after reset release

    ae_pkg::fix_t                code_q  [$];   // Expected results in arrival order
    ae_pkg::fix_t [`AE_N_IN-1:0] recon_q [$];
    logic                        code_avail;
    logic                        recon_avail;
    ae_pkg::fix_t                exp_code;      // Queue fronts as plain signals
    ae_pkg::fix_t [`AE_N_IN-1:0] exp_recon;

    autoencoder_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .x           (x),
        .w_hid       (w_hid),
        .b_hid       (b_hid),
        .w_code      (w_code),
        .b_code      (b_code),
        .w_dec       (w_dec),
        .b_dec       (b_dec),
        .code        (code),
        .code_valid  (code_valid),
        .recon       (recon),
        .recon_valid (recon_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Small signed value of about +-2.0 in Q8.8
    function automatic ae_pkg::fix_t small_rand();
        logic [31:0] r;
        r = $random(seed);
        return ae_pkg::fix_t'($signed(r[9:0]));
    endfunction

    // Reference step that floors the product, adds and clamps to 16 bits
    function automatic longint mac_step(longint acc, ae_pkg::fix_t a, ae_pkg::fix_t wgt);
        longint p;
        longint s;
        p = longint'(a) * longint'(wgt);
        p = p >>> `AE_FRAC_BITS;
        s = acc + p;
        if (s > 32767) begin
            s = 32767;
        end else if (s < -32768) begin
            s = -32768;
        end
        return s;
    endfunction

    function automatic ae_pkg::fix_t activate(longint v, bit relu);
        if (relu && v < 0) begin
            return '0;
        end
        return ae_pkg::fix_t'(v);
    endfunction

    // Whole network on the current inputs and weights
    task automatic predict(output ae_pkg::fix_t code_e,
                           output ae_pkg::fix_t [`AE_N_IN-1:0] recon_e);
        ae_pkg::fix_t hid [`AE_N_HID];
        longint       acc;
        for (int j = 0; j < `AE_N_HID; j++) begin
            acc = longint'(b_hid[j]);
            for (int i = 0; i < `AE_N_IN; i++) begin
                acc = mac_step(acc, x[i], w_hid[j*`AE_N_IN + i]);
            end
            hid[j] = activate(acc, 1'b1);
        end
        acc = longint'(b_code);
        for (int i = 0; i < `AE_N_HID; i++) begin
            acc = mac_step(acc, hid[i], w_code[i]);
        end
        code_e = activate(acc, 1'b1);
        for (int j = 0; j < `AE_N_IN; j++) begin
            acc = mac_step(longint'(b_dec[j]), code_e, w_dec[j]);  // Single code input
            recon_e[j] = activate(acc, 1'b0);
        end
    endtask

    task automatic refresh_fronts();
        code_avail  = (code_q.size() > 0);
        recon_avail = (recon_q.size() > 0);
        if (code_avail) begin
            exp_code = code_q[0];
        end else begin
            exp_code = '0;
        end
        if (recon_avail) begin
            exp_recon = recon_q[0];
        end else begin
            exp_recon = '0;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // One-cycle start where keep=0 marks a start the DUT should drop
    task automatic issue_start(input bit keep);
        ae_pkg::fix_t                code_e;
        ae_pkg::fix_t [`AE_N_IN-1:0] recon_e;
        if (keep) begin
            predict(code_e, recon_e);
            code_q.push_back(code_e);
            recon_q.push_back(recon_e);
            refresh_fronts();
        end
        start    = 1'b1;
        start_ok = keep;
        @(posedge clk);
        #1;
        start    = 1'b0;
        start_ok = 1'b0;
    endtask

    // Wait up to 20 cycles for the queues to empty
    task automatic wait_drain();
        int n;
        n = 0;
        while ((code_q.size() != 0 || recon_q.size() != 0) && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        idle_cycles(6);  // Room for a stray valid from a dropped start
    endtask

    task automatic randomize_vector();
        for (int i = 0; i < `AE_N_IN; i++) begin
            x[i] = small_rand();
        end
    endtask

    task automatic randomize_weights();
        for (int k = 0; k < `AE_N_HID*`AE_N_IN; k++) w_hid[k] = small_rand();
        for (int k = 0; k < `AE_N_HID; k++) begin
            b_hid[k]  = small_rand();
            w_code[k] = small_rand();
        end
        for (int k = 0; k < `AE_N_IN; k++) begin
            w_dec[k] = small_rand();
            b_dec[k] = small_rand();
        end
        b_code = small_rand();
    endtask

    // Retire results on the edge that samples the strobe
    always @(posedge clk) begin
        if (!reset && code_valid && code_q.size() > 0) void'(code_q.pop_front());
        if (!reset && recon_valid && recon_q.size() > 0) void'(recon_q.pop_front());
        refresh_fronts();
    end

    // Outputs quiet during and just after reset
    a_reset_quiet: assert property (@(negedge clk) (reset || quiet) |->
        (!code_valid && !recon_valid && code == '0 && recon == '0))
        else begin
            other_errors++;
            $display("outputs not cleared by reset at %0t", $time);
        end

    a_code_latency: assert property (@(posedge clk) disable iff (reset)
        start_ok |-> ##14 code_valid)
        else begin
            other_errors++;
            $display("code_valid missing 14 cycles after start, at %0t", $time);
        end

    a_recon_latency: assert property (@(posedge clk) disable iff (reset)
        start_ok |-> ##16 recon_valid)
        else begin
            other_errors++;
            $display("recon_valid missing 16 cycles after start, at %0t", $time);
        end

    // Mid-cycle checks on settled outputs
    a_code_expected: assert property (@(negedge clk) disable iff (reset)
        code_valid |-> code_avail)
        else begin
            other_errors++;
            $display("extra code_valid with no vector in flight at %0t", $time);
        end

    a_recon_expected: assert property (@(negedge clk) disable iff (reset)
        recon_valid |-> recon_avail)
        else begin
            other_errors++;
            $display("extra recon_valid with no vector in flight at %0t", $time);
        end

    a_code_value: assert property (@(negedge clk) disable iff (reset)
        (code_valid && code_avail) |-> (code == exp_code))
        else begin
            mismatch_errors++;
            $display("mismatch at %0t: code expected %h actual %h", $time, exp_code, code);
        end

    a_recon_value: assert property (@(negedge clk) disable iff (reset)
        (recon_valid && recon_avail) |-> (recon == exp_recon))
        else begin
            mismatch_errors++;
            $display("mismatch at %0t: recon expected %h actual %h", $time, exp_recon, recon);
        end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: run did not end within %0d cycles", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        seed = 70;
        mismatch_errors = 0;
        other_errors = 0;
        reset = 1'b1;
        start = 1'b0;
        start_ok = 1'b0;
        quiet = 1'b0;
        x = '0;
        w_hid = '0;
        b_hid = '0;
        w_code = '0;
        b_code = '0;
        w_dec = '0;
        b_dec = '0;
        refresh_fronts();
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        quiet = 1'b1;
        idle_cycles(4);
        quiet = 1'b0;

        randomize_weights();  // Single vector for latency and value
        randomize_vector();
        issue_start(1'b1);
        wait_drain();

        x      = {`AE_N_IN{16'h7FFF}};  // Drive every sum past the rails
        w_hid  = {(`AE_N_HID*`AE_N_IN){16'h7FFF}};
        b_hid  = '0;
        w_code = {`AE_N_HID{16'h7FFF}};
        b_code = '0;
        for (int j = 0; j < `AE_N_IN; j++) begin
            w_dec[j] = (j % 2 == 0) ? 16'h7FFF : 16'h8000;  // Alternate rails
        end
        b_dec = '0;
        issue_start(1'b1);
        wait_drain();

        randomize_weights();  // Negative code so the decoder shows its biases
        w_code = {`AE_N_HID{16'hFF00}};
        b_code = 16'hFF00;
        randomize_vector();
        issue_start(1'b1);
        wait_drain();

        randomize_weights();  // Back to back at the 7-cycle period
        for (int v = 0; v < 20; v++) begin
            randomize_vector();
            issue_start(1'b1);
            idle_cycles(6);
        end
        wait_drain();

        randomize_vector();   // Early start lands mid-accumulation
        issue_start(1'b1);
        idle_cycles(2);
        randomize_vector();
        issue_start(1'b0);
        wait_drain();

        if (code_q.size() != 0 || recon_q.size() != 0) begin
            other_errors++;
            $display("results still outstanding at end of run");
        end
        $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: hw/autoencoder_top.sv
`timescale 1ns/1ps
`include "ae_consts.svh"

// 6 -> 6 (ReLU) -> 1 (ReLU) -> 6 (linear), one layer per stage
// code_valid 14 cycles and recon_valid 16 cycles after start
module autoencoder_top (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     start,    // At least 7 cycles apart
    input  ae_pkg::fix_t [`AE_N_IN-1:0]              x,
    input  ae_pkg::fix_t [`AE_N_HID*`AE_N_IN-1:0]    w_hid,    // Output-major
    input  ae_pkg::fix_t [`AE_N_HID-1:0]             b_hid,
    input  ae_pkg::fix_t [`AE_N_CODE*`AE_N_HID-1:0]  w_code,
    input  ae_pkg::fix_t                             b_code,   // Single code bias
    input  ae_pkg::fix_t [`AE_N_IN*`AE_N_CODE-1:0]   w_dec,
    input  ae_pkg::fix_t [`AE_N_IN-1:0]              b_dec,
    output ae_pkg::fix_t                             code,     // Bottleneck tap
    output logic                                     code_valid,
    output ae_pkg::fix_t [`AE_N_IN-1:0]              recon,
    output logic                                     recon_valid
);

    ae_pkg::fix_t [`AE_N_HID-1:0] hid_y;     // Hidden activations
    logic                         hid_done;  // Starts the code layer

    // Hidden encoder, 7 cycles
    dense_layer #(
        .N_IN  (`AE_N_IN),
        .N_OUT (`AE_N_HID),
        .RELU  (1'b1)
    ) u_enc_hidden (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .x     (x),
        .w     (w_hid),
        .b     (b_hid),
        .y     (hid_y),
        .done  (hid_done)
    );

    // Code encoder, 7 cycles, output brought out as the code tap
    dense_layer #(
        .N_IN  (`AE_N_HID),
        .N_OUT (`AE_N_CODE),
        .RELU  (1'b1)
    ) u_enc_code (
        .clk   (clk),
        .reset (reset),
        .start (hid_done),
        .x     (hid_y),
        .w     (w_code),
        .b     (b_code),
        .y     (code),
        .done  (code_valid)
    );

    // Linear decoder, 2 cycles
    dense_layer #(
        .N_IN  (`AE_N_CODE),
        .N_OUT (`AE_N_IN),
        .RELU  (1'b0)
    ) u_dec (
        .clk   (clk),
        .reset (reset),
        .start (code_valid),  // Code strobe doubles as decoder start
        .x     (code),
        .w     (w_dec),
        .b     (b_dec),
        .y     (recon),
        .done  (recon_valid)
    );

endmodule

// File: hw/dense_layer.sv
`timescale 1ns/1ps

// Dense layer, serial over inputs, parallel over outputs
// Start sampled at edge 0, done high for the sample at edge N_IN+1
module dense_layer #(
    parameter int N_IN  = 6,     // Inputs, one consumed per cycle
    parameter int N_OUT = 6,     // Outputs, one MAC each
    parameter bit RELU  = 1'b1   // Clip negatives at emit
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,  // Ignored unless idle
    input  ae_pkg::fix_t [N_IN-1:0]       x,      // Slice i is sample i
    input  ae_pkg::fix_t [N_IN*N_OUT-1:0] w,      // Slice j*N_IN+i is weight i -> j
    input  ae_pkg::fix_t [N_OUT-1:0]      b,      // Bias per output
    output ae_pkg::fix_t [N_OUT-1:0]      y,      // Held until next done
    output logic                          done    // One-cycle strobe
);

    // Wide enough to hold N_IN itself
    localparam int idx_w = $clog2(N_IN + 1);

    ae_pkg::layer_state_t state;
    logic [idx_w-1:0]     idx;       // Next input to consume in accum
    logic [idx_w-1:0]     step;      // Input fed to the MACs this cycle
    logic                 load;      // Accepted start
    logic                 step_en;   // Accumulators take the MAC result

    ae_pkg::fix_t  x_reg   [N_IN];   // Latched input vector
    ae_pkg::prod_t acc     [N_OUT];  // Running sums, always in fix_t range
    ae_pkg::fix_t  mac_a;            // Shared sample operand
    ae_pkg::fix_t  mac_b   [N_OUT];  // Weight per output
    ae_pkg::prod_t mac_acc [N_OUT];  // Bias on step 0, else the stored sum
    ae_pkg::prod_t mac_out [N_OUT];

    assign load    = (state == ae_pkg::idle) && start;
    assign step_en = load || (state == ae_pkg::accum);

    // Step 0 runs straight off the ports on the start edge,
    // which keeps the layer at N_IN+1 cycles and a 7-cycle period
    assign step  = (state == ae_pkg::idle) ? '0 : idx;
    assign mac_a = (state == ae_pkg::idle) ? x[0] : x_reg[step];

    for (genvar j = 0; j < N_OUT; j++) begin : g_out
        assign mac_acc[j] = (state == ae_pkg::idle) ? ae_pkg::prod_t'(b[j]) : acc[j];
        assign mac_b[j]   = w[j*N_IN + int'(step)];  // Row j, column step

        fixed_mac u_mac (
            .acc_in  (mac_acc[j]),
            .a       (mac_a),
            .b       (mac_b[j]),
            .acc_out (mac_out[j])
        );
    end

    // Control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ae_pkg::idle;
            idx   <= '0;
            done  <= 1'b0;
            y     <= '0;
        end else begin
            done <= 1'b0;  // Strobe by default
            case (state)
                ae_pkg::idle: begin
                    if (start) begin
                        idx <= idx_w'(1);   // Step 0 taken on this edge
                        if (N_IN == 1) begin
                            state <= ae_pkg::emit;  // Single input, nothing left
                        end else begin
                            state <= ae_pkg::accum;
                        end
                    end
                end
                ae_pkg::accum: begin
                    idx <= idx + 1'b1;
                    if (idx == idx_w'(N_IN - 1)) begin
                        state <= ae_pkg::emit;      // Last input this cycle
                    end
                end
                ae_pkg::emit: begin
                    for (int j = 0; j < N_OUT; j++) begin
                        // Clamp already done in the MAC, only ReLU here
                        if (RELU && (acc[j] < 0)) begin
                            y[j] <= '0;
                        end else begin
                            y[j] <= ae_pkg::fix_t'(acc[j]);
                        end
                    end
                    done  <= 1'b1;
                    state <= ae_pkg::idle;
                end
                default: state <= ae_pkg::idle;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < N_IN; i++) begin
                x_reg[i] <= x[i];
            end
        end
        if (step_en) begin
            for (int j = 0; j < N_OUT; j++) begin
                acc[j] <= mac_out[j];
            end
        end
    end

    // Strobe never stretches
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done);

    // Index stays inside the input vector while accumulating
    a_idx_range: assert property (@(posedge clk) disable iff (reset)
        (state == ae_pkg::accum) |-> (idx < idx_w'(N_IN)));

    // Fixed latency from accepted start to done
    a_latency: assert property (@(posedge clk) disable iff (reset)
        load |=> (!done) [*N_IN] ##1 done);

endmodule

// File: hw/fixed_mac.sv
`timescale 1ns/1ps
`include "ae_consts.svh"

// Single MAC step in Q8.8: acc_out = clamp(acc_in + floor(a*b))
module fixed_mac (
    input  ae_pkg::prod_t acc_in,  // Running sum, already in fix_t range
    input  ae_pkg::fix_t  a,       // Sample
    input  ae_pkg::fix_t  b,       // Weight
    output ae_pkg::prod_t acc_out  // Clamped sum, sign extended
);

    // fix_t limits at prod_t width
    localparam ae_pkg::prod_t sat_max = 2 ** (`AE_WIDTH - 1) - 1;    // 0x7FFF
    localparam ae_pkg::prod_t sat_min = -(2 ** (`AE_WIDTH - 1));     // 0x8000

    ae_pkg::prod_t prod;     // Q16.16 full product
    ae_pkg::prod_t prod_fl;  // Back on the Q8.8 scale
    ae_pkg::prod_t sum;      // Unclamped

    // Widen first so the multiply runs at 32 bits, signed
    assign prod = ae_pkg::prod_t'(a) * ae_pkg::prod_t'(b);

    // Arithmetic shift floors toward minus infinity
    assign prod_fl = prod >>> `AE_FRAC_BITS;

    // Cannot overflow 32 bits: |prod_fl| < 2^22, |acc_in| <= 2^15
    assign sum = acc_in + prod_fl;

    always_comb begin
        if (sum > sat_max) begin
            acc_out = sat_max;      // Positive rail
        end else if (sum < sat_min) begin
            acc_out = sat_min;      // Negative rail
        end else begin
            acc_out = sum;
        end
    end

endmodule

// File: hw/ae_pkg.sv
`include "ae_consts.svh"

package ae_pkg;

    // Q8.8 sample, weight or bias
    typedef logic signed [`AE_WIDTH-1:0] fix_t;

    // Full product or running sum before the clamp
    typedef logic signed [2*`AE_WIDTH-1:0] prod_t;

    // Dense layer sequencing
    typedef enum logic [1:0] {
        idle,   // Waiting for start, takes step 0 on the start edge
        accum,  // Remaining inputs, one per cycle
        emit    // ReLU, output register, done strobe
    } layer_state_t;

endpackage

// File: hw/ae_consts.svh
`ifndef AE_CONSTS_SVH
`define AE_CONSTS_SVH

// Q8.8 word format
`define AE_WIDTH 16

// Fraction bits, also the product shift
`define AE_FRAC_BITS 8

// Network shape: 6 -> 6 -> 1 -> 6

// Samples per input vector, also the reconstruction width
`define AE_N_IN 6

// Hidden encoder outputs
`define AE_N_HID 6

// Bottleneck width
`define AE_N_CODE 1

`endif
